// File: verilog/cache_defines.svh
// Cache geometry macros, included by the cache package and by every RTL file that splits addresses
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ----------------------------------------------------------
// Processor side
// ----------------------------------------------------------
`define CACHE_WORD_W    32      // Data word
`define CACHE_ADDR_W    30      // Word address, byte offset already stripped

// ----------------------------------------------------------
// Line and set geometry
// ----------------------------------------------------------
`define CACHE_LINE_W    128     // Four words per line
`define CACHE_OFFS_W    2       // Word within the line
`define CACHE_SET_W     2
`define CACHE_SETS      4

// Remaining upper address bits
`define CACHE_TAG_W     26
`define CACHE_LADDR_W   28      // Line address seen by the slow memory

`endif

// File: verilog/cache_pkg.sv
// Shared address, data and state types for the instruction and data caches
`include "cache_defines.svh"

package cache_pkg;

    // ----------------------------------------------------------
    // Data
    // ----------------------------------------------------------
    typedef logic [`CACHE_WORD_W-1:0]  word_t;
    typedef logic [`CACHE_LINE_W-1:0]  line_t;

    // ----------------------------------------------------------
    // Addresses
    // ----------------------------------------------------------
    // Processor word address is {tag, set, word offset}
    typedef logic [`CACHE_ADDR_W-1:0]  waddr_t;
    typedef logic [`CACHE_LADDR_W-1:0] laddr_t;     // {tag, set}
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_SET_W-1:0]   set_t;

    // Data-cache controller
    // S_WB writes the dirty victim back, S_RD refills the missing line
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_RD   = 2'd2,
        S_WB   = 2'd3
    } dc_state_e;

endpackage

// File: verilog/cache_ways.sv
// Two-way set storage used by both caches: hit check, word read and write, LRU and line refill
`include "cache_defines.svh"

module cache_ways #(
    parameter int HAS_DIRTY = 1         // 0 builds a read-only array
) (
    input  logic              clk,
    input  logic              i_rst_n,
    // Processor access
    input  logic              i_read,
    input  logic              i_write,
    input  cache_pkg::waddr_t i_addr,
    input  cache_pkg::word_t  i_wdata,
    // Refill from the controller
    input  logic              i_fill,
    input  cache_pkg::line_t  i_fill_data,
    input  logic              i_fill_dirty,
    output logic              o_hit,
    output cache_pkg::word_t  o_rdata,
    // LRU way of the addressed set
    output logic              o_victim_dirty,
    output cache_pkg::laddr_t o_victim_addr,
    output cache_pkg::line_t  o_victim_data
);

    localparam logic DIRTY_EN = (HAS_DIRTY != 0);

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    logic [1:0][`CACHE_SETS-1:0] valid_q;
    logic [1:0][`CACHE_SETS-1:0] dirty_q;
    logic [`CACHE_SETS-1:0]      lru_q;         // Way to replace next

    cache_pkg::tag_t  tag_q  [2][`CACHE_SETS];
    cache_pkg::line_t data_q [2][`CACHE_SETS];

    cache_pkg::tag_t          tag;
    cache_pkg::set_t          set_idx;
    logic [`CACHE_OFFS_W-1:0] offs;
    logic [1:0]               hit_way;
    logic                     hit_idx;
    logic                     vict_idx;
    logic                     acc_hit;
    logic                     wr_hit;

    assign tag     = i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign set_idx = i_addr[`CACHE_OFFS_W +: `CACHE_SET_W];
    assign offs    = i_addr[`CACHE_OFFS_W-1:0];

    // ----------------------------------------------------------
    // Lookup
    // ----------------------------------------------------------
    assign hit_way[0] = valid_q[0][set_idx] && (tag_q[0][set_idx] == tag);
    assign hit_way[1] = valid_q[1][set_idx] && (tag_q[1][set_idx] == tag);
    assign hit_idx    = hit_way[1];             // A tag lives in one way only
    assign o_hit      = |hit_way;

    assign acc_hit = (i_read | i_write) & o_hit;
    assign wr_hit  = i_write & o_hit;

    // Selected word of the hitting line
    assign o_rdata = data_q[hit_idx][set_idx][offs * `CACHE_WORD_W +: `CACHE_WORD_W];

    // The victim is also the way that a refill overwrites
    assign vict_idx       = lru_q[set_idx];
    assign o_victim_dirty = DIRTY_EN & dirty_q[vict_idx][set_idx];
    assign o_victim_addr  = {tag_q[vict_idx][set_idx], set_idx};
    assign o_victim_data  = data_q[vict_idx][set_idx];

    // ----------------------------------------------------------
    // Valid, dirty and LRU bits
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (i_fill) begin
                valid_q[vict_idx][set_idx] <= 1'b1;
                dirty_q[vict_idx][set_idx] <= DIRTY_EN & i_fill_dirty;
            end
            if (wr_hit)
                dirty_q[hit_idx][set_idx] <= DIRTY_EN;
            if (acc_hit)
                lru_q[set_idx] <= ~hit_idx;     // Other way becomes LRU
        end
    end

    // Tags and lines
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[vict_idx][set_idx]  <= tag;
            data_q[vict_idx][set_idx] <= i_fill_data;
        end else if (wr_hit) begin
            data_q[hit_idx][set_idx][offs * `CACHE_WORD_W +: `CACHE_WORD_W] <= i_wdata;
        end
    end

    // Controller refills only while the request misses
    a_fill_not_on_write_hit: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(i_fill && wr_hit)
    );

endmodule

// File: verilog/icache.sv
// Read-only instruction cache: refill FSM around a two-way array without dirty state
`include "cache_defines.svh"

module icache (
    input  logic              clk,
    input  logic              i_rst_n,
    // Processor side
    input  logic              i_read,
    input  cache_pkg::waddr_t i_addr,
    output cache_pkg::word_t  o_rdata,
    output logic              o_stall,
    // Memory side
    output logic              o_mem_read,
    output cache_pkg::laddr_t o_mem_addr,
    input  cache_pkg::line_t  i_mem_rdata,
    input  logic              i_mem_ready
);

    typedef enum logic {
        S_IDLE,
        S_RD
    } ic_state_e;

    ic_state_e state_q;
    logic      hit;
    logic      fill;

    assign o_stall = i_read & ~hit;
    assign fill    = (state_q == S_RD) & i_mem_ready;

    cache_ways #(
        .HAS_DIRTY (0)
    ) u_ways (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_read         (i_read),
        .i_write        (1'b0),
        .i_addr         (i_addr),
        .i_wdata        ('0),
        .i_fill         (fill),
        .i_fill_data    (i_mem_rdata),
        .i_fill_dirty   (1'b0),
        .o_hit          (hit),
        .o_rdata        (o_rdata),
        .o_victim_dirty (),
        .o_victim_addr  (),
        .o_victim_data  ()
    );

    // Refill FSM, the strobe follows the state
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= S_IDLE;
            o_mem_read <= 1'b0;
        end else if (state_q == S_IDLE && o_stall) begin
            state_q    <= S_RD;
            o_mem_read <= 1'b1;
        end else if (fill) begin
            state_q    <= S_IDLE;
            o_mem_read <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && o_stall)
            o_mem_addr <= i_addr[`CACHE_ADDR_W-1:`CACHE_OFFS_W];
    end

    // Refill request and its line address held until the memory answers
    a_read_held_until_ready: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_mem_read && !i_mem_ready |=> o_mem_read && $stable(o_mem_addr)
    );

endmodule

// File: verilog/dcache.sv
// Write-back, write-allocate data cache: miss FSM and memory port around a two-way array
`include "cache_defines.svh"

module dcache (
    input  logic              clk,
    input  logic              i_rst_n,
    // Processor side
    input  logic              i_read,
    input  logic              i_write,
    input  cache_pkg::waddr_t i_addr,
    input  cache_pkg::word_t  i_wdata,
    output cache_pkg::word_t  o_rdata,
    output logic              o_stall,
    // Memory side
    output logic              o_mem_read,
    output logic              o_mem_write,
    output cache_pkg::laddr_t o_mem_addr,
    output cache_pkg::line_t  o_mem_wdata,
    input  cache_pkg::line_t  i_mem_rdata,
    input  logic              i_mem_ready
);

    cache_pkg::dc_state_e state_q;
    cache_pkg::dc_state_e state_d;

    logic              hit;
    logic              fill;
    logic              victim_dirty;
    cache_pkg::laddr_t victim_addr;
    cache_pkg::line_t  victim_data;
    cache_pkg::laddr_t line_addr;

    assign line_addr = i_addr[`CACHE_ADDR_W-1:`CACHE_OFFS_W];
    assign o_stall   = (i_read | i_write) & ~hit;
    assign fill      = (state_q == cache_pkg::S_RD) & i_mem_ready;

    cache_ways #(
        .HAS_DIRTY (1)
    ) u_ways (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_fill         (fill),
        .i_fill_data    (i_mem_rdata),
        .i_fill_dirty   (i_write),              // Pending write lands on the next cycle
        .o_hit          (hit),
        .o_rdata        (o_rdata),
        .o_victim_dirty (victim_dirty),
        .o_victim_addr  (victim_addr),
        .o_victim_data  (victim_data)
    );

    // ----------------------------------------------------------
    // Miss FSM
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            cache_pkg::S_IDLE:
                if (o_stall)
                    state_d = victim_dirty ? cache_pkg::S_WB : cache_pkg::S_RD;
            cache_pkg::S_WB:
                if (i_mem_ready)
                    state_d = cache_pkg::S_RD;  // Straight into the refill
            cache_pkg::S_RD:
                if (i_mem_ready)
                    state_d = cache_pkg::S_IDLE;
            default:
                state_d = cache_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= cache_pkg::S_IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_mem_read  <= (state_d == cache_pkg::S_RD);
            o_mem_write <= (state_d == cache_pkg::S_WB);
        end
    end

    // Memory address and line, held until ready
    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::S_IDLE && o_stall) begin
            o_mem_addr  <= victim_dirty ? victim_addr : line_addr;
            o_mem_wdata <= victim_data;
        end else if (state_q == cache_pkg::S_WB && i_mem_ready) begin
            o_mem_addr  <= line_addr;
        end
    end

    a_mem_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(o_mem_read && o_mem_write)
    );

endmodule

// File: verilog/cache_subsystem.sv
// Memory-side top level: instruction and data caches side by side, each with its own memory port
module cache_subsystem (
    input  logic              clk,
    input  logic              i_rst_n,
    // Instruction fetch
    input  logic              i_i_read,
    input  cache_pkg::waddr_t i_i_addr,
    output cache_pkg::word_t  o_i_rdata,
    output logic              o_i_stall,
    // Data access
    input  logic              i_d_read,
    input  logic              i_d_write,
    input  cache_pkg::waddr_t i_d_addr,
    input  cache_pkg::word_t  i_d_wdata,
    output cache_pkg::word_t  o_d_rdata,
    output logic              o_d_stall,
    // Instruction memory
    output logic              o_imem_read,
    output cache_pkg::laddr_t o_imem_addr,
    input  cache_pkg::line_t  i_imem_rdata,
    input  logic              i_imem_ready,
    // Data memory
    output logic              o_dmem_read,
    output logic              o_dmem_write,
    output cache_pkg::laddr_t o_dmem_addr,
    output cache_pkg::line_t  o_dmem_wdata,
    input  cache_pkg::line_t  i_dmem_rdata,
    input  logic              i_dmem_ready
);

    // ----------------------------------------------------------
    // Instruction cache
    // ----------------------------------------------------------
    icache u_icache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_read      (i_i_read),
        .i_addr      (i_i_addr),
        .o_rdata     (o_i_rdata),
        .o_stall     (o_i_stall),
        .o_mem_read  (o_imem_read),
        .o_mem_addr  (o_imem_addr),
        .i_mem_rdata (i_imem_rdata),
        .i_mem_ready (i_imem_ready)
    );

    // ----------------------------------------------------------
    // Data cache
    // ----------------------------------------------------------
    dcache u_dcache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_read      (i_d_read),
        .i_write     (i_d_write),
        .i_addr      (i_d_addr),
        .i_wdata     (i_d_wdata),
        .o_rdata     (o_d_rdata),
        .o_stall     (o_d_stall),
        .o_mem_read  (o_dmem_read),
        .o_mem_write (o_dmem_write),
        .o_mem_addr  (o_dmem_addr),
        .o_mem_wdata (o_dmem_wdata),
        .i_mem_rdata (i_dmem_rdata),
        .i_mem_ready (i_dmem_ready)
    );

endmodule

// File: sim/tb_slow_memory.sv
// Slow line memory for the cache testbench: random ready delay, backing store and write log
module tb_slow_memory #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_read,
    input  logic              i_write,
    input  cache_pkg::laddr_t i_addr,
    input  cache_pkg::line_t  i_wdata,
    output cache_pkg::line_t  o_rdata,
    output logic              o_ready,
    output int                o_wr_count        // Write log, one count per stored line
);
    timeunit 1ns;
    timeprecision 1ps;

    cache_pkg::line_t store [256];
    integer           seed;
    logic             busy;
    int               wait_cnt;

    // Random initial content, one fixed seed per instance
    initial begin
        seed = SEED;
        for (int i = 0; i < 256; i++)
            store[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end

    // ----------------------------------------------------------
    // Request handling on the falling edge
    // ----------------------------------------------------------
    always @(negedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ready    <= 1'b0;
            o_rdata    <= '0;
            busy       <= 1'b0;
            wait_cnt   <= 0;
            o_wr_count <= 0;
        end else if (o_ready) begin
            o_ready <= 1'b0;                    // One-cycle pulse
            busy    <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                o_ready <= 1'b1;
                if (i_read)
                    o_rdata <= store[i_addr[7:0]];
                if (i_write) begin
                    store[i_addr[7:0]] <= i_wdata;
                    o_wr_count         <= o_wr_count + 1;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (i_read || i_write) begin
            busy     <= 1'b1;
            wait_cnt <= $unsigned($random(seed)) % 4;   // Ready after 1 to 4 cycles
        end
    end

endmodule

// File: sim/tb_cache_subsystem.sv
// Testbench top for the cache subsystem: random processor traffic checked against a word model
module tb_cache_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED         = 91229;
    localparam int RESET_CYCLES = 8;
    localparam int N_DATA       = 400;
    localparam int N_FETCH      = 200;
    localparam int N_DIRECTED   = 5;
    localparam int MAX_CYCLES   = (N_DATA + N_FETCH + N_DIRECTED) * 12 + RESET_CYCLES;
    localparam int N_WORDS      = 48;   // 12 lines, 3 tags in each of the 4 sets

    logic              clk;
    logic              rst_n;
    logic              i_read;
    logic              d_read;
    logic              d_write;
    cache_pkg::waddr_t i_addr;
    cache_pkg::waddr_t d_addr;
    cache_pkg::word_t  d_wdata;
    cache_pkg::word_t  i_rdata;
    cache_pkg::word_t  d_rdata;
    logic              i_stall;
    logic              d_stall;
    logic              imem_read;
    logic              imem_ready;
    logic              dmem_read;
    logic              dmem_write;
    logic              dmem_ready;
    cache_pkg::laddr_t imem_addr;
    cache_pkg::laddr_t dmem_addr;
    cache_pkg::line_t  imem_rdata;
    cache_pkg::line_t  dmem_rdata;
    cache_pkg::line_t  dmem_wdata;
    int                dmem_wr_count;

    cache_pkg::word_t dmodel [N_WORDS];
    cache_pkg::word_t imodel [N_WORDS];
    integer           seed = SEED;
    int               cycle_cnt = 0;
    logic             d_acked = 1'b0;
    logic             i_acked = 1'b0;
    logic             d_held = 1'b0;
    logic             i_held = 1'b0;
    logic [157:0]     d_snap;
    logic [28:0]      i_snap;

    cache_subsystem UUT (
        .clk (clk), .i_rst_n (rst_n),
        .i_i_read (i_read), .i_i_addr (i_addr), .o_i_rdata (i_rdata), .o_i_stall (i_stall),
        .i_d_read (d_read), .i_d_write (d_write), .i_d_addr (d_addr), .i_d_wdata (d_wdata),
        .o_d_rdata (d_rdata), .o_d_stall (d_stall),
        .o_imem_read (imem_read), .o_imem_addr (imem_addr),
        .i_imem_rdata (imem_rdata), .i_imem_ready (imem_ready),
        .o_dmem_read (dmem_read), .o_dmem_write (dmem_write), .o_dmem_addr (dmem_addr),
        .o_dmem_wdata (dmem_wdata), .i_dmem_rdata (dmem_rdata), .i_dmem_ready (dmem_ready)
    );

    tb_slow_memory #(.SEED (SEED + 1)) u_imem (
        .clk (clk), .i_rst_n (rst_n), .i_read (imem_read), .i_write (1'b0),
        .i_addr (imem_addr), .i_wdata ('0), .o_rdata (imem_rdata), .o_ready (imem_ready),
        .o_wr_count ()
    );

    tb_slow_memory #(.SEED (SEED)) u_dmem (
        .clk (clk), .i_rst_n (rst_n), .i_read (dmem_read), .i_write (dmem_write),
        .i_addr (dmem_addr), .i_wdata (dmem_wdata), .o_rdata (dmem_rdata), .o_ready (dmem_ready),
        .o_wr_count (dmem_wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_value(input string test, input logic [127:0] exp, input logic [127:0] act);
        fail_text($sformatf("ERR %s expected %0h actual %0h", test, exp, act));
    endtask

    // Model line in memory layout, word 0 in the low bits
    function automatic cache_pkg::line_t model_line(input cache_pkg::laddr_t a);
        return {dmodel[a*4+3], dmodel[a*4+2], dmodel[a*4+1], dmodel[a*4]};
    endfunction

    // ----------------------------------------------------------
    // Processor side, request held while stalled
    // ----------------------------------------------------------
    task automatic data_access(input logic wr, input int widx, input cache_pkg::word_t wd,
                               output cache_pkg::word_t rd, output int waits);
        @(negedge clk);
        d_read  = ~wr;
        d_write = wr;
        d_addr  = cache_pkg::waddr_t'(widx);
        d_wdata = wd;
        waits   = 0;
        @(posedge clk);
        while (d_stall) begin
            waits++;
            @(posedge clk);
        end
        rd = d_rdata;                           // Value before the completing edge
        if (wr)
            dmodel[widx] = wd;
    endtask

    task automatic fetch(input int widx, output cache_pkg::word_t rd, output int waits);
        @(negedge clk);
        i_read = 1'b1;
        i_addr = cache_pkg::waddr_t'(widx);
        waits  = 0;
        @(posedge clk);
        while (i_stall) begin
            waits++;
            @(posedge clk);
        end
        rd = i_rdata;
    endtask

    // Timeout and write-back checks
    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < MAX_CYCLES)
            else fail_text($sformatf("timeout, run did not finish in %0d cycles", MAX_CYCLES));
        d_acked = dmem_ready;
        i_acked = imem_ready;
        if (rst_n && dmem_ready && dmem_write) begin
            assert (dmem_addr < 12) else fail_text("write-back to a line outside the test range");
            assert (dmem_wdata == model_line(dmem_addr))
                else fail_value("write-back", model_line(dmem_addr), dmem_wdata);
        end
    end

    // Memory strobes exclusive and stable until ready
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(dmem_read && dmem_write))
                else fail_text("data memory read and write strobes high together");
            if (d_held && !d_acked)
                assert ({dmem_read, dmem_write, dmem_addr, dmem_wdata} === d_snap)
                    else fail_text("data memory request changed before ready");
            if (i_held && !i_acked)
                assert ({imem_read, imem_addr} == i_snap)
                    else fail_text("instruction memory request changed before ready");
        end
        d_held = dmem_read | dmem_write;
        d_snap = {dmem_read, dmem_write, dmem_addr, dmem_wdata};
        i_held = imem_read;
        i_snap = {imem_read, imem_addr};
    end

    initial begin
        cache_pkg::word_t got;
        cache_pkg::word_t exp;
        cache_pkg::word_t wd;
        int               waits;
        int               widx;
        int               last_d;
        int               last_i;
        int               n_d;
        int               n_i;
        logic             wr;
        logic             again;

        rst_n   = 1'b0;
        i_read  = 1'b0;
        i_addr  = '0;
        d_read  = 1'b0;
        d_write = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int w = 0; w < N_WORDS; w++) begin
            dmodel[w] = u_dmem.store[w / 4][(w % 4) * 32 +: 32];
            imodel[w] = u_imem.store[w / 4][(w % 4) * 32 +: 32];
        end

        // Empty caches after reset
        assert (!imem_read && !dmem_read && !dmem_write)
            else fail_text("memory strobe high after reset");
        data_access(1'b0, 0, '0, got, waits);
        assert (waits > 0) else fail_text("first data access after reset did not stall");
        assert (got == dmodel[0]) else fail_value("data read", dmodel[0], got);
        last_i = $unsigned($random(seed)) % N_WORDS;
        fetch(last_i, got, waits);
        assert (waits > 0) else fail_text("first fetch after reset did not stall");
        assert (got == imodel[last_i]) else fail_value("fetch", imodel[last_i], got);

        // Three dirty tags in set 0 force an eviction
        data_access(1'b1, 0, $random(seed), got, waits);
        data_access(1'b1, 16, $random(seed), got, waits);
        data_access(1'b1, 32, $random(seed), got, waits);
        assert (dmem_wr_count > 0)
            else fail_text("no write-back after three dirty tags in one set");
        last_d = 32;

        n_d = 0;
        n_i = 0;
        while (n_d < N_DATA || n_i < N_FETCH) begin
            again = ($unsigned($random(seed)) % 4) == 0;   // Same line as the last access
            if (n_i >= N_FETCH || (n_d < N_DATA && ($unsigned($random(seed)) % 3) != 0)) begin
                widx = again ? (last_d / 4) * 4 + $unsigned($random(seed)) % 4
                             : $unsigned($random(seed)) % N_WORDS;
                wr   = $random(seed) & 1;
                wd   = $random(seed);
                exp  = dmodel[widx];
                data_access(wr, widx, wd, got, waits);
                if (!wr)
                    assert (got == exp) else fail_value("data read", exp, got);
                last_d = widx;
                n_d++;
            end else begin
                widx = again ? (last_i / 4) * 4 + $unsigned($random(seed)) % 4
                             : $unsigned($random(seed)) % N_WORDS;
                fetch(widx, got, waits);
                assert (got == imodel[widx]) else fail_value("fetch", imodel[widx], got);
                last_i = widx;
                n_i++;
            end
            if (again)
                assert (waits == 0) else fail_value("re-access stall cycles", 0, waits);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_ways.sv
verilog/icache.sv
verilog/dcache.sv
verilog/cache_subsystem.sv
sim/tb_slow_memory.sv
sim/tb_cache_subsystem.sv

// File: Bender.yml
package:
  name: cache_subsystem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_ways.sv
      - verilog/icache.sv
      - verilog/dcache.sv
      - verilog/cache_subsystem.sv
  - target: simulation
    files:
      - sim/tb_slow_memory.sv
      - sim/tb_cache_subsystem.sv
